/* files.f */
+incdir+rtl
rtl/thread_pkg.sv
rtl/thread_csr.sv
rtl/thread_sched.sv
rtl/thread_alloc.sv
rtl/thread_ctrl.sv
dv/thread_clk_gen.sv
dv/thread_ctrl_tb.sv

/* dv/thread_ctrl_tb.sv */
// ==========================================================================
// Thread controller testbench: stimulus table, reference model, error count
// ==========================================================================

`timescale 1ns/1ps

`include "thread_ctrl_cfg.svh"

module thread_ctrl_tb;

    import thread_pkg::*;

    localparam int RST_CYCLES = 8;
    localparam int NO_WR      = -1;                    // Row without a pc write
    localparam int OP_NONE    = 0;
    localparam int OP_INIT    = 1;
    localparam int OP_KILL    = 2;
    localparam int OP_SLP     = 3;
    localparam int OP_WAKE    = 4;

    // One table row, stimulus followed by expected flags and state
    typedef struct packed {
        trd_cmd_t cmd;
        pc_wr_t   upd;
        logic     atomic;
        logic     stall;
        trd_vec_t exp_valid;                           // After the edge
        trd_vec_t exp_run;
        logic     exp_inv;                             // Within the cycle
        logic     exp_err;
    } row_t;

    logic     clk;
    logic     rst_n;
    trd_cmd_t cmd;
    pc_wr_t   pc_upd;
    logic     atomic;
    logic     stall;
    trd_idx_t cur_trd;
    trd_idx_t nxt_trd;
    trd_idx_t new_trd;
    trd_vec_t valid_trd;
    trd_vec_t run_trd;
    logic     trd_full;
    logic     invalid_op;
    logic     error;
    pc_t      cur_pc;

    row_t     rows [$];
    int       checks;
    int       errors;
    int       cycles;

    // Reference model state
    pc_t      m_pc  [`THREAD_NUM];
    trd_idx_t m_par [`THREAD_NUM];
    trd_idx_t m_cur;
    pc_t      m_last;                                  // Pc shown at the previous edge
    trd_vec_t cur_valid;
    trd_vec_t cur_run;

    thread_clk_gen #(
        .PERIOD_NS  (8),
        .RST_CYCLES (RST_CYCLES)
    ) i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    thread_ctrl i_thread_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .pc_upd     (pc_upd),
        .atomic     (atomic),
        .stall      (stall),
        .cur_trd    (cur_trd),
        .nxt_trd    (nxt_trd),
        .new_trd    (new_trd),
        .valid_trd  (valid_trd),
        .run_trd    (run_trd),
        .trd_full   (trd_full),
        .invalid_op (invalid_op),
        .error      (error),
        .cur_pc     (cur_pc)
    );

    function automatic trd_idx_t lowest_free(input trd_vec_t v);
        trd_idx_t idx;
        logic     found;
        idx   = '0;
        found = 1'b0;
        for (int i = 0; i < `THREAD_NUM; i++) begin
            if (!found && !v[i]) begin
                idx   = trd_idx_t'(i);
                found = 1'b1;
            end
        end
        return idx;
    endfunction

    // First running slot after cur in circular order, cur itself if none other
    function automatic trd_idx_t next_running(input trd_idx_t cur, input trd_vec_t run);
        trd_idx_t idx;
        trd_idx_t pick;
        logic     found;
        pick  = cur;
        found = 1'b0;
        for (int k = 1; k <= `THREAD_NUM; k++) begin
            idx = trd_idx_t'((int'(cur) + k) % `THREAD_NUM);
            if (!found && run[idx]) begin
                pick  = idx;
                found = 1'b1;
            end
        end
        return pick;
    endfunction

    // Kill, slp and wake need a live target acted on by itself or its parent
    function automatic logic predict_refuse(input trd_cmd_t c);
        logic ctl;
        logic ok;
        ctl = !c.init && (c.kill || c.slp || c.wake);
        ok  = cur_valid[c.obj_trd] &&
              ((c.act_trd == c.obj_trd) || (c.act_trd == m_par[c.obj_trd]));
        return ctl && !ok;
    endfunction

    function automatic pc_t shown_pc(input logic stl);
        return stl ? m_last : m_pc[m_cur];
    endfunction

    task automatic add_row(input int op, input int act, input int obj, input pc_t new_pc,
                           input int pc_trd, input pc_t pc_val, input logic atm,
                           input logic stl, input trd_vec_t ev, input trd_vec_t er,
                           input logic ei, input logic ee);
        row_t r;
        r             = '0;
        r.cmd.init    = (op == OP_INIT);
        r.cmd.kill    = (op == OP_KILL);
        r.cmd.slp     = (op == OP_SLP);
        r.cmd.wake    = (op == OP_WAKE);
        r.cmd.act_trd = trd_idx_t'(act);
        r.cmd.obj_trd = trd_idx_t'(obj);
        r.cmd.new_pc  = new_pc;
        r.upd.wr      = (pc_trd != NO_WR);
        r.upd.trd     = (pc_trd == NO_WR) ? trd_idx_t'(0) : trd_idx_t'(pc_trd);
        r.upd.pc      = pc_val;
        r.atomic      = atm;
        r.stall       = stl;
        r.exp_valid   = ev;
        r.exp_run     = er;
        r.exp_inv     = ei;
        r.exp_err     = ee;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // Fill every slot from thread 0, then overflow
        add_row(OP_INIT, 0, 0, 32'h0000_2000, NO_WR, '0, 0, 0, 8'h03, 8'h03, 0, 0);
        add_row(OP_INIT, 0, 0, 32'h0000_3000, NO_WR, '0, 0, 0, 8'h07, 8'h07, 0, 0);
        add_row(OP_INIT, 0, 0, 32'h0000_4000, NO_WR, '0, 0, 0, 8'h0f, 8'h0f, 0, 0);
        add_row(OP_INIT, 0, 0, 32'h0000_5000, NO_WR, '0, 0, 0, 8'h1f, 8'h1f, 0, 0);
        add_row(OP_INIT, 0, 0, 32'h0000_6000, NO_WR, '0, 0, 0, 8'h3f, 8'h3f, 0, 0);
        add_row(OP_INIT, 0, 0, 32'h0000_7000, NO_WR, '0, 0, 0, 8'h7f, 8'h7f, 0, 0);
        add_row(OP_INIT, 0, 0, 32'h0000_8000, NO_WR, '0, 0, 0, 8'hff, 8'hff, 0, 0);
        add_row(OP_INIT, 0, 0, 32'h0000_9000, NO_WR, '0, 0, 0, 8'hff, 8'hff, 0, 1);
        // Free a middle slot and reuse it from thread 1
        add_row(OP_KILL, 0, 3, '0, NO_WR, '0, 0, 0, 8'hf7, 8'hf7, 0, 0);
        add_row(OP_INIT, 1, 0, 32'h0000_a000, NO_WR, '0, 0, 0, 8'hff, 8'hff, 0, 0);
        // Permission cases
        add_row(OP_SLP, 1, 3, '0, NO_WR, '0, 0, 0, 8'hff, 8'hf7, 0, 0);
        add_row(OP_SLP, 2, 3, '0, NO_WR, '0, 0, 0, 8'hff, 8'hf7, 1, 0);
        add_row(OP_WAKE, 1, 3, '0, NO_WR, '0, 0, 0, 8'hff, 8'hff, 0, 0);
        add_row(OP_KILL, 4, 4, '0, NO_WR, '0, 0, 0, 8'hef, 8'hef, 0, 0);
        add_row(OP_KILL, 0, 4, '0, NO_WR, '0, 0, 0, 8'hef, 8'hef, 1, 0);
        add_row(OP_SLP, 5, 5, '0, NO_WR, '0, 0, 0, 8'hef, 8'hcf, 0, 0);
        add_row(OP_KILL, 2, 6, '0, NO_WR, '0, 0, 0, 8'hef, 8'hcf, 1, 0);
        add_row(OP_KILL, 0, 6, '0, NO_WR, '0, 0, 0, 8'haf, 8'h8f, 0, 0);
        add_row(OP_SLP, 5, 0, '0, NO_WR, '0, 0, 0, 8'haf, 8'h8f, 1, 0);
        // Round robin over 0, 1, 2, 3 and 7
        repeat (4) add_row(OP_NONE, 0, 0, '0, NO_WR, '0, 0, 0, 8'haf, 8'h8f, 0, 0);
        add_row(OP_SLP, 0, 1, '0, NO_WR, '0, 0, 0, 8'haf, 8'h8d, 0, 0);
        add_row(OP_SLP, 0, 2, '0, NO_WR, '0, 0, 0, 8'haf, 8'h89, 0, 0);
        add_row(OP_SLP, 1, 3, '0, NO_WR, '0, 0, 0, 8'haf, 8'h81, 0, 0);
        add_row(OP_SLP, 7, 7, '0, NO_WR, '0, 0, 0, 8'haf, 8'h01, 0, 0);
        repeat (3) add_row(OP_NONE, 0, 0, '0, NO_WR, '0, 0, 0, 8'haf, 8'h01, 0, 0);
        add_row(OP_WAKE, 0, 7, '0, NO_WR, '0, 0, 0, 8'haf, 8'h81, 0, 0);
        add_row(OP_WAKE, 0, 1, '0, NO_WR, '0, 0, 0, 8'haf, 8'h83, 0, 0);
        // Pc writes, then atomic and stall holds
        add_row(OP_NONE, 0, 0, '0, 0, 32'h0000_1100, 0, 0, 8'haf, 8'h83, 0, 0);
        add_row(OP_NONE, 0, 0, '0, 1, 32'h0000_2100, 0, 0, 8'haf, 8'h83, 0, 0);
        add_row(OP_NONE, 0, 0, '0, 7, 32'h0000_8100, 0, 0, 8'haf, 8'h83, 0, 0);
        repeat (3) add_row(OP_NONE, 0, 0, '0, NO_WR, '0, 0, 0, 8'haf, 8'h83, 0, 0);
        repeat (3) add_row(OP_NONE, 0, 0, '0, NO_WR, '0, 1, 0, 8'haf, 8'h83, 0, 0);
        add_row(OP_NONE, 0, 0, '0, NO_WR, '0, 0, 0, 8'haf, 8'h83, 0, 0);
        add_row(OP_NONE, 0, 0, '0, 0, 32'h0000_1200, 0, 1, 8'haf, 8'h83, 0, 0);
        add_row(OP_NONE, 0, 0, '0, 1, 32'h0000_2200, 0, 1, 8'haf, 8'h83, 0, 0);
        add_row(OP_NONE, 0, 0, '0, 7, 32'h0000_8200, 0, 1, 8'haf, 8'h83, 0, 0);
        repeat (2) add_row(OP_NONE, 0, 0, '0, NO_WR, '0, 0, 0, 8'haf, 8'h83, 0, 0);
    endtask

    task automatic expect_equal(input int row, input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t: row %0d %s is %0h, expected %0h", $time, row, what, got, exp);
        end
    endtask

    // Registered state left by the previous row
    task automatic check_state(input int row, input logic stl);
        expect_equal(row, "valid_trd", valid_trd, cur_valid);
        expect_equal(row, "run_trd", run_trd, cur_run);
        expect_equal(row, "trd_full", trd_full, &cur_valid);
        if (!(&cur_valid)) begin
            expect_equal(row, "new_trd", new_trd, lowest_free(cur_valid));
        end
        expect_equal(row, "cur_trd", cur_trd, m_cur);
        expect_equal(row, "nxt_trd", nxt_trd, next_running(m_cur, cur_run));
        expect_equal(row, "cur_pc", cur_pc, shown_pc(stl));
    endtask

    task automatic check_flags(input int row, input row_t r);
        logic ovf;
        ovf = r.cmd.init && (&cur_valid);
        expect_equal(row, "invalid_op", invalid_op, r.exp_inv);
        expect_equal(row, "error", error, r.exp_err);
        checks++;
        assert ((predict_refuse(r.cmd) === r.exp_inv) && (ovf === r.exp_err)) else begin
            errors++;
            $display("Table row %0d expects flags that break the permission rules", row);
        end
    endtask

    // Model update at the edge ending the row
    task automatic advance_model(input row_t r);
        trd_idx_t slot;
        pc_t      shown;
        shown = shown_pc(r.stall);
        slot  = lowest_free(cur_valid);
        if (r.upd.wr) begin
            m_pc[r.upd.trd] = r.upd.pc;
        end
        if (r.cmd.init && !(&cur_valid)) begin
            m_pc[slot]  = r.cmd.new_pc;                // Entry pc beats a pc write
            m_par[slot] = r.cmd.act_trd;
        end
        if (!(r.atomic || r.stall)) begin
            m_cur = next_running(m_cur, cur_run);
        end
        m_last    = shown;
        cur_valid = r.exp_valid;
        cur_run   = r.exp_run;
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > RST_CYCLES + 2 * rows.size() + 20) begin
            $display("Timeout: test did not finish within %0d clock cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        row_t r;
        cmd    = '0;
        pc_upd = '0;
        atomic = 1'b0;
        stall  = 1'b0;
        checks = 0;
        errors = 0;
        cycles = 0;
        build_table();
        for (int t = 0; t < `THREAD_NUM; t++) begin
            m_pc[t]  = '0;
            m_par[t] = '0;
        end
        m_pc[0]   = `START_PC;                         // Boot thread
        m_cur     = '0;
        m_last    = `START_PC;
        cur_valid = trd_vec_t'(1);
        cur_run   = trd_vec_t'(1);
        wait (rst_n === 1'b1);
        @(posedge clk);
        for (int i = 0; i <= rows.size(); i++) begin
            if (i < rows.size()) begin
                r = rows[i];
            end else begin
                r           = '0;                      // Idle cycle for the last state check
                r.exp_valid = cur_valid;
                r.exp_run   = cur_run;
            end
            #1;
            cmd    = r.cmd;
            pc_upd = r.upd;
            atomic = r.atomic;
            stall  = r.stall;
            @(negedge clk);
            check_state(i, r.stall);
            if (i < rows.size()) begin
                check_flags(i, r);
            end
            advance_model(r);
            @(posedge clk);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* dv/thread_clk_gen.sv */
// ==========================================================================
// Testbench clock and power-on reset generator
// ==========================================================================

`timescale 1ns/1ps

module thread_clk_gen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;                               // Released just after an edge
    end

endmodule

/* rtl/thread_ctrl.sv */
// ==========================================================================
// Fetch-stage thread controller: eight state registers, allocator, scheduler
// ==========================================================================

`timescale 1ns/1ps

`include "thread_ctrl_cfg.svh"

module thread_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  thread_pkg::trd_cmd_t cmd,              // Single-cycle thread command
    input  thread_pkg::pc_wr_t   pc_upd,           // Pc write into one thread
    input  logic                 atomic,           // Keep the current thread
    input  logic                 stall,            // Freeze thread and pc view
    output thread_pkg::trd_idx_t cur_trd,
    output thread_pkg::trd_idx_t nxt_trd,
    output thread_pkg::trd_idx_t new_trd,          // Slot the next init would take
    output thread_pkg::trd_vec_t valid_trd,
    output thread_pkg::trd_vec_t run_trd,
    output logic                 trd_full,
    output logic                 invalid_op,       // Command refused by its target
    output logic                 error,            // Init while all slots are used
    output thread_pkg::pc_t      cur_pc
);

    import thread_pkg::*;

    trd_idx_t obj_trd;
    logic     init_ok;
    trd_cmd_t csr_cmd;
    trd_vec_t refuse;
    pc_t      trd_pc [`THREAD_NUM];
    pc_t      last_pc;
    pc_t      sel_pc;

    thread_alloc i_alloc (
        .valid_trd (valid_trd),
        .init      (cmd.init),
        .obj_in    (cmd.obj_trd),
        .new_trd   (new_trd),
        .obj_trd   (obj_trd),
        .trd_full  (trd_full),
        .init_ok   (init_ok),
        .error     (error)
    );

    // Command as seen by the state registers
    // Init takes priority, so a raised init blocks kill, slp and wake
    // even when it is dropped for overflow
    always_comb begin
        csr_cmd         = cmd;
        csr_cmd.init    = init_ok;
        csr_cmd.kill    = cmd.kill & ~cmd.init;
        csr_cmd.slp     = cmd.slp & ~cmd.init & ~cmd.kill;
        csr_cmd.wake    = cmd.wake & ~cmd.init & ~cmd.kill & ~cmd.slp;
        csr_cmd.obj_trd = obj_trd;
    end

    for (genvar i = 0; i < `THREAD_NUM; i++) begin : g_csr
        thread_csr #(
            .THREAD_ID (i)
        ) i_csr (
            .clk     (clk),
            .rst_n   (rst_n),
            .cmd     (csr_cmd),
            .pc_upd  (pc_upd),
            .valid   (valid_trd[i]),
            .running (run_trd[i]),
            .par_trd (),                               // Checked locally in each register
            .pc      (trd_pc[i]),
            .refuse  (refuse[i])
        );
    end

    assign invalid_op = |refuse;

    thread_sched i_sched (
        .clk     (clk),
        .rst_n   (rst_n),
        .run_trd (run_trd),
        .hold    (atomic | stall),
        .cur_trd (cur_trd),
        .nxt_trd (nxt_trd)
    );

    assign sel_pc = trd_pc[cur_trd];

    // Last shown pc, replayed while stalled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_pc <= `START_PC;
        end else begin
            last_pc <= cur_pc;
        end
    end

    assign cur_pc = stall ? last_pc : sel_pc;

endmodule

/* rtl/thread_alloc.sv */
// ==========================================================================
// Free-slot search, full and overflow flags, command target selection
// ==========================================================================

`timescale 1ns/1ps

`include "thread_ctrl_cfg.svh"

module thread_alloc (
    input  thread_pkg::trd_vec_t valid_trd,
    input  logic                 init,
    input  thread_pkg::trd_idx_t obj_in,           // Target named by the command
    output thread_pkg::trd_idx_t new_trd,          // Lowest free slot
    output thread_pkg::trd_idx_t obj_trd,          // Target seen by the state registers
    output logic                 trd_full,
    output logic                 init_ok,
    output logic                 error             // Init with no free slot
);

    import thread_pkg::*;

    trd_idx_t free_idx;

    // Priority search from the top so the lowest free slot wins
    always_comb begin
        free_idx = '0;
        for (int i = `THREAD_NUM - 1; i >= 0; i--) begin
            if (!valid_trd[i]) begin
                free_idx = trd_idx_t'(i);
            end
        end
    end

    assign new_trd  = free_idx;
    assign trd_full = &valid_trd;
    assign error    = init & trd_full;
    assign init_ok  = init & ~trd_full;
    assign obj_trd  = init ? free_idx : obj_in;

endmodule

/* rtl/thread_sched.sv */
// ==========================================================================
// Round-robin search for the next running thread and current-thread register
// ==========================================================================

`timescale 1ns/1ps

`include "thread_ctrl_cfg.svh"

module thread_sched (
    input  logic                 clk,
    input  logic                 rst_n,
    input  thread_pkg::trd_vec_t run_trd,
    input  logic                 hold,             // Atomic or stall
    output thread_pkg::trd_idx_t cur_trd,
    output thread_pkg::trd_idx_t nxt_trd
);

    import thread_pkg::*;

    localparam int N = `THREAD_NUM;

    logic [2*N-1:0]   run_dbl;
    logic [N-1:0]     run_rot;
    logic [`THREAD_W:0] start;
    trd_idx_t         off;
    logic             found;

    // Doubling the vector turns the circular search into a plain slice
    assign run_dbl = {run_trd, run_trd};
    assign start   = {1'b0, cur_trd} + 1'b1;       // One past the current thread
    assign run_rot = run_dbl[start +: N];          // Bit k is slot cur_trd+1+k

    // Lowest set bit of the rotated vector
    always_comb begin
        off   = '0;
        found = 1'b0;
        for (int i = N - 1; i >= 0; i--) begin
            if (run_rot[i]) begin
                off   = trd_idx_t'(i);
                found = 1'b1;
            end
        end
    end

    // Sole running thread lands at offset N-1, which wraps back to cur_trd
    assign nxt_trd = found ? trd_idx_t'(start + off) : cur_trd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_trd <= '0;
        end else if (!hold) begin
            cur_trd <= nxt_trd;
        end
    end

endmodule

/* rtl/thread_csr.sv */
// ==========================================================================
// Per-thread state register: valid, running, parent, pc and permission check
// ==========================================================================

`timescale 1ns/1ps

`include "thread_ctrl_cfg.svh"

module thread_csr #(
    parameter int THREAD_ID = 0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  thread_pkg::trd_cmd_t cmd,              // Target already resolved
    input  thread_pkg::pc_wr_t   pc_upd,
    output logic                 valid,
    output logic                 running,
    output thread_pkg::trd_idx_t par_trd,          // Thread that created this one
    output thread_pkg::pc_t      pc,
    output logic                 refuse            // Kill, slp or wake not allowed
);

    import thread_pkg::*;

    localparam trd_idx_t MY_ID  = trd_idx_t'(THREAD_ID);
    localparam logic     RST_ON = (THREAD_ID == 0);  // Only thread 0 boots alive
    localparam pc_t      RST_PC = (THREAD_ID == 0) ? `START_PC : pc_t'(0);

    logic hit;
    logic ctl_op;
    logic allowed;
    logic pc_hit;

    assign hit    = (cmd.obj_trd == MY_ID);
    assign ctl_op = cmd.kill | cmd.slp | cmd.wake;

    // A live thread may be controlled by itself or by its parent
    assign allowed = valid & ((cmd.act_trd == MY_ID) | (cmd.act_trd == par_trd));

    assign refuse = hit & ~cmd.init & ctl_op & ~allowed;
    assign pc_hit = pc_upd.wr & (pc_upd.trd == MY_ID);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid   <= RST_ON;
            running <= RST_ON;
            par_trd <= '0;
        end else if (hit) begin
            if (cmd.init) begin
                valid   <= 1'b1;
                running <= 1'b1;
                par_trd <= cmd.act_trd;                // Creator becomes the parent
            end else if (allowed) begin
                if (cmd.kill) begin
                    valid   <= 1'b0;
                    running <= 1'b0;
                end else if (cmd.slp) begin
                    running <= 1'b0;
                end else if (cmd.wake) begin
                    running <= 1'b1;
                end
            end
        end
    end

    // Entry pc from init wins over a pc write in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RST_PC;
        end else if (hit & cmd.init) begin
            pc <= cmd.new_pc;
        end else if (pc_hit) begin
            pc <= pc_upd.pc;
        end
    end

endmodule

/* rtl/thread_pkg.sv */
// ==========================================================================
// Thread controller types: thread index, thread vector, pc, command, pc write
// ==========================================================================

`include "thread_ctrl_cfg.svh"

package thread_pkg;

    typedef logic [`THREAD_W-1:0]   trd_idx_t;     // Slot number
    typedef logic [`THREAD_NUM-1:0] trd_vec_t;     // One bit per slot
    typedef logic [`PC_W-1:0]       pc_t;

    // One thread command, at most one strobe high per cycle
    // Priority if several are set: init, kill, slp, wake
    typedef struct packed {
        logic     init;                            // Create a thread in a free slot
        logic     kill;                            // Remove the target thread
        logic     slp;                             // Put the target to sleep
        logic     wake;                            // Resume the target
        trd_idx_t act_trd;                         // Thread issuing the command
        trd_idx_t obj_trd;                         // Target of kill, slp or wake
        pc_t      new_pc;                          // Entry pc of a created thread
    } trd_cmd_t;

    // Program counter update for one thread
    typedef struct packed {
        logic     wr;                              // Write strobe
        trd_idx_t trd;                             // Thread whose pc is written
        pc_t      pc;                              // New pc value
    } pc_wr_t;

endpackage

/* rtl/thread_ctrl_cfg.svh */
// ==========================================================================
// Thread controller configuration: slot count, index and pc widths, boot pc
// ==========================================================================

`ifndef THREAD_CTRL_CFG_SVH
`define THREAD_CTRL_CFG_SVH

// Number of hardware thread slots
`define THREAD_NUM 8

// Bits needed to name one slot, log2 of THREAD_NUM
`define THREAD_W 3

// Program counter width
`define PC_W 32

// Thread 0 starts here after reset
`define START_PC 32'h0000_1000

`endif
